/* common/issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// Entries per issue queue
`define ISSUE_QUEUE_DEPTH 8

// Micro-ops per dispatch bundle
`define ISSUE_DISPATCH_W 2

// One queue and one result bus per functional-unit class
`define ISSUE_NUM_UNITS 2

`define ISSUE_DATA_W 32
`define ISSUE_MUL_LAT 3
`define ISSUE_TAG_W 5
`define ISSUE_SQN_W 6

// Width of a free-entry count, 0 to depth inclusive
`define ISSUE_CNT_W ($clog2(`ISSUE_QUEUE_DEPTH + 1))

`endif

/* common/issuePkg.sv */
`include "issue_params.svh"

package issuePkg;

    // Enum value doubles as the queue index
    typedef enum logic [0:0] {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } FuType;

    typedef enum logic [1:0] {
        ADD = 2'd0,
        SUB = 2'd1,
        AND = 2'd2,
        XOR = 2'd3
    } AluOp;

    typedef logic [`ISSUE_SQN_W-1:0] SqN;

    // Tag 0 is the hardwired zero register
    typedef logic [`ISSUE_TAG_W-1:0] Tag;

    typedef struct packed {
        FuType       fu;
        AluOp        op;
        Tag          tagA;
        Tag          tagB;
        logic        availA;
        logic        availB;
        logic        useImm;
        logic [15:0] imm;
        Tag          tagDst;
        SqN          sqN;
    } MicroOp;

    // True when a is strictly younger than b, tolerant of wrap
    function automatic logic sqnYounger(SqN a, SqN b);
        logic signed [`ISSUE_SQN_W-1:0] diff;
        diff = a - b;
        return diff > 0;
    endfunction

endpackage

/* source/dispatchRouter.sv */
`include "issue_params.svh"

module dispatchRouter
    import issuePkg::*;
(
    input  logic [`ISSUE_DISPATCH_W-1:0] dispatchValid,
    input  MicroOp                       dispatchUop [`ISSUE_DISPATCH_W],
    input  logic [`ISSUE_CNT_W-1:0]      freeCount [`ISSUE_NUM_UNITS],
    input  logic                         flushValid,
    output logic                         accept,
    output logic [`ISSUE_DISPATCH_W-1:0] enqValid [`ISSUE_NUM_UNITS]
);

    localparam int NU = `ISSUE_NUM_UNITS;
    localparam int DW = `ISSUE_DISPATCH_W;
    localparam int CNT_W = `ISSUE_CNT_W;

    logic [CNT_W-1:0] demand [NU];
    logic [NU-1:0]    fits;

    // Count bundle ops per unit and check each against its queue's room
    always_comb begin
        for (int u = 0; u < NU; u++) begin
            demand[u] = '0;
            for (int s = 0; s < DW; s++) begin
                if (dispatchValid[s] && int'(dispatchUop[s].fu) == u) begin
                    demand[u] = demand[u] + 1'b1;
                end
            end
            fits[u] = demand[u] <= freeCount[u];
        end
    end

    // Whole bundle or nothing
    assign accept = (&fits) && !flushValid;

    // Steer each slot to the queue named by its unit class
    always_comb begin
        for (int u = 0; u < NU; u++) begin
            for (int s = 0; s < DW; s++) begin
                enqValid[u][s] = accept && dispatchValid[s] && int'(dispatchUop[s].fu) == u;
            end
        end
    end

endmodule

/* issueQueue/issueQueue.sv */
`include "issue_params.svh"

module issueQueue
    import issuePkg::*;
#(
    parameter FuType UNIT_FU = FU_ALU
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`ISSUE_DISPATCH_W-1:0] enqValid,
    input  MicroOp                       enqUop [`ISSUE_DISPATCH_W],
    input  logic [`ISSUE_NUM_UNITS-1:0]  resultValid,
    input  Tag                           resultTag [`ISSUE_NUM_UNITS],
    input  logic                         flushValid,
    input  SqN                           flushSqN,
    output logic [`ISSUE_CNT_W-1:0]      freeCount,
    output logic                         issueValid,
    output MicroOp                       issueUop
);

    localparam int DEPTH = `ISSUE_QUEUE_DEPTH;
    localparam int DW = `ISSUE_DISPATCH_W;
    localparam int NU = `ISSUE_NUM_UNITS;
    localparam int CNT_W = `ISSUE_CNT_W;
    localparam int IDX_W = $clog2(DEPTH);

    // Index order is age order, entries [0, count) are occupied
    MicroOp           entries [DEPTH];
    logic [CNT_W-1:0] count;

    MicroOp           woken [DEPTH];
    logic [DEPTH-1:0] ready;
    logic             selFound;
    logic [IDX_W-1:0] selIdx;
    logic             issueFire;
    MicroOp           nextEntries [DEPTH];
    logic [CNT_W-1:0] nextCount;

    function automatic logic tagWoken(Tag t);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < NU; b++) begin
            if (resultValid[b] && resultTag[b] == t) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Fold this cycle's broadcasts into every entry
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            woken[i] = entries[i];
            woken[i].availA = entries[i].availA | tagWoken(entries[i].tagA);
            woken[i].availB = entries[i].availB | tagWoken(entries[i].tagB);
            ready[i] = (i < count) && woken[i].availA && woken[i].availB;
        end
    end

    // Oldest ready entry wins
    always_comb begin
        selFound = 1'b0;
        selIdx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                selFound = 1'b1;
                selIdx = IDX_W'(i);
            end
        end
    end

    assign issueFire = selFound && !flushValid;

    always_comb begin
        logic [CNT_W-1:0] fill;
        MicroOp           incoming;
        nextEntries = woken;
        fill = count;
        incoming = '0;
        if (flushValid) begin
            // Keep the prefix up to the first younger entry
            for (int i = DEPTH - 1; i >= 0; i--) begin
                if (i < count && sqnYounger(entries[i].sqN, flushSqN)) begin
                    fill = CNT_W'(i);
                end
            end
        end else begin
            if (issueFire) begin
                for (int i = 0; i < DEPTH - 1; i++) begin
                    if (i >= selIdx) begin
                        nextEntries[i] = woken[i + 1];
                    end
                end
                fill = count - 1'b1;
            end
            // New ops land behind the compacted tail
            for (int s = 0; s < DW; s++) begin
                if (enqValid[s] && enqUop[s].fu == UNIT_FU && fill < DEPTH) begin
                    incoming = enqUop[s];
                    incoming.availA = enqUop[s].availA || enqUop[s].tagA == '0
                                      || tagWoken(enqUop[s].tagA);
                    incoming.availB = enqUop[s].availB || enqUop[s].tagB == '0
                                      || tagWoken(enqUop[s].tagB);
                    nextEntries[fill[IDX_W-1:0]] = incoming;
                    fill = fill + 1'b1;
                end
            end
        end
        nextCount = fill;
    end

    always_ff @(posedge clk) begin
        entries <= nextEntries;
        issueUop <= woken[selIdx];
        if (rst) begin
            count <= '0;
            issueValid <= 1'b0;
        end else begin
            count <= nextCount;
            issueValid <= issueFire;
        end
    end

    assign freeCount = CNT_W'(DEPTH) - count;

endmodule

/* source/executeWriteback.sv */
`include "issue_params.svh"

module executeWriteback
    import issuePkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`ISSUE_NUM_UNITS-1:0] issueValid,
    input  MicroOp                      issueUop [`ISSUE_NUM_UNITS],
    input  logic                        flushValid,
    input  SqN                          flushSqN,
    output logic [`ISSUE_NUM_UNITS-1:0] resultValid,
    output Tag                          resultTag [`ISSUE_NUM_UNITS],
    output logic [`ISSUE_DATA_W-1:0]    resultData [`ISSUE_NUM_UNITS]
);

    localparam int NU = `ISSUE_NUM_UNITS;
    localparam int DW = `ISSUE_DATA_W;
    localparam int REGS = 2 ** `ISSUE_TAG_W;
    localparam int ALU = int'(FU_ALU);
    localparam int MUL = int'(FU_MUL);
    // Last stage feeds the result register, which is the final stage
    localparam int MUL_STAGES = `ISSUE_MUL_LAT - 1;
    localparam int LAST = MUL_STAGES - 1;

    logic [DW-1:0] regFile [REGS];

    logic [DW-1:0] opA [NU];
    logic [DW-1:0] opB [NU];
    logic [NU-1:0] issueLive;
    logic [DW-1:0] aluOut;
    logic [DW-1:0] mulProduct;

    logic [MUL_STAGES-1:0] mulValid;
    logic [MUL_STAGES-1:0] mulKeep;
    logic [DW-1:0]         mulData [MUL_STAGES];
    Tag                    mulTag [MUL_STAGES];
    SqN                    mulSqN [MUL_STAGES];

    function automatic logic [DW-1:0] readReg(Tag t);
        return (t == '0) ? '0 : regFile[t];
    endfunction

    // Operand read, and drop of issues killed by a flush or with no destination
    always_comb begin
        for (int u = 0; u < NU; u++) begin
            opA[u] = readReg(issueUop[u].tagA);
            opB[u] = issueUop[u].useImm ? DW'(issueUop[u].imm) : readReg(issueUop[u].tagB);
            issueLive[u] = issueValid[u] && issueUop[u].tagDst != '0
                           && !(flushValid && sqnYounger(issueUop[u].sqN, flushSqN));
        end
    end

    always_comb begin
        case (issueUop[ALU].op)
            ADD:     aluOut = opA[ALU] + opB[ALU];
            SUB:     aluOut = opA[ALU] - opB[ALU];
            AND:     aluOut = opA[ALU] & opB[ALU];
            default: aluOut = opA[ALU] ^ opB[ALU];
        endcase
    end

    // Low half of the product only
    assign mulProduct = opA[MUL] * opB[MUL];

    always_comb begin
        for (int k = 0; k < MUL_STAGES; k++) begin
            mulKeep[k] = mulValid[k] && !(flushValid && sqnYounger(mulSqN[k], flushSqN));
        end
    end

    always_ff @(posedge clk) begin
        mulData[0] <= mulProduct;
        mulTag[0] <= issueUop[MUL].tagDst;
        mulSqN[0] <= issueUop[MUL].sqN;
        for (int k = 1; k < MUL_STAGES; k++) begin
            mulData[k] <= mulData[k - 1];
            mulTag[k] <= mulTag[k - 1];
            mulSqN[k] <= mulSqN[k - 1];
        end
        resultTag[ALU] <= issueUop[ALU].tagDst;
        resultData[ALU] <= aluOut;
        resultTag[MUL] <= mulTag[LAST];
        resultData[MUL] <= mulData[LAST];
        if (rst) begin
            mulValid <= '0;
            resultValid <= '0;
            for (int r = 0; r < REGS; r++) begin
                regFile[r] <= '0;
            end
        end else begin
            mulValid[0] <= issueLive[MUL];
            for (int k = 1; k < MUL_STAGES; k++) begin
                mulValid[k] <= mulKeep[k - 1];
            end
            resultValid[ALU] <= issueLive[ALU];
            resultValid[MUL] <= mulKeep[LAST];
            // Writeback shares the edge with the broadcast
            if (issueLive[ALU]) begin
                regFile[issueUop[ALU].tagDst] <= aluOut;
            end
            if (mulKeep[LAST]) begin
                regFile[mulTag[LAST]] <= mulData[LAST];
            end
        end
    end

endmodule

/* source/issueTop.sv */
`include "issue_params.svh"

module issueTop
    import issuePkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`ISSUE_DISPATCH_W-1:0] dispatchValid,
    input  MicroOp                       dispatchUop [`ISSUE_DISPATCH_W],
    input  logic                         flushValid,
    input  SqN                           flushSqN,
    output logic                         accept,
    output logic [`ISSUE_NUM_UNITS-1:0]  resultValid,
    output Tag                           resultTag [`ISSUE_NUM_UNITS],
    output logic [`ISSUE_DATA_W-1:0]     resultData [`ISSUE_NUM_UNITS]
);

    logic [`ISSUE_CNT_W-1:0]      freeCount [`ISSUE_NUM_UNITS];
    logic [`ISSUE_DISPATCH_W-1:0] enqValid [`ISSUE_NUM_UNITS];
    logic [`ISSUE_NUM_UNITS-1:0]  issueValid;
    MicroOp                       issueUop [`ISSUE_NUM_UNITS];

    dispatchRouter i_router (
        .dispatchValid (dispatchValid),
        .dispatchUop   (dispatchUop),
        .freeCount     (freeCount),
        .flushValid    (flushValid),
        .accept        (accept),
        .enqValid      (enqValid)
    );

    // One queue per unit class, every queue sees every result bus
    for (genvar u = 0; u < `ISSUE_NUM_UNITS; u++) begin : gQueue
        issueQueue #(
            .UNIT_FU (FuType'(u))
        ) i_queue (
            .clk         (clk),
            .rst         (rst),
            .enqValid    (enqValid[u]),
            .enqUop      (dispatchUop),
            .resultValid (resultValid),
            .resultTag   (resultTag),
            .flushValid  (flushValid),
            .flushSqN    (flushSqN),
            .freeCount   (freeCount[u]),
            .issueValid  (issueValid[u]),
            .issueUop    (issueUop[u])
        );
    end

    executeWriteback i_exec (
        .clk         (clk),
        .rst         (rst),
        .issueValid  (issueValid),
        .issueUop    (issueUop),
        .flushValid  (flushValid),
        .flushSqN    (flushSqN),
        .resultValid (resultValid),
        .resultTag   (resultTag),
        .resultData  (resultData)
    );

endmodule

/* bench/issue_sva.sv */
`include "issue_params.svh"

module issueSva
    import issuePkg::*;
(
    input logic                        clk,
    input logic                        rst,
    input logic [`ISSUE_NUM_UNITS-1:0] issueValid,
    input logic [`ISSUE_NUM_UNITS-1:0] resultValid,
    input Tag                          resultTag [`ISSUE_NUM_UNITS]
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ALU = int'(FU_ALU);
    localparam int MUL = int'(FU_MUL);

    // Tag 0 is the zero register and never a destination
    for (genvar u = 0; u < `ISSUE_NUM_UNITS; u++) begin : gUnit
        resultTagNonZero: assert property (@(posedge clk) disable iff (rst)
            resultValid[u] |-> resultTag[u] != '0)
            else $error("result bus %0d broadcast tag 0", u);
    end

    noResultInReset: assert property (@(posedge clk)
        rst |=> resultValid == '0)
        else $error("result valid raised while in reset");

    aluFollowsIssue: assert property (@(posedge clk) disable iff (rst)
        resultValid[ALU] |-> $past(issueValid[ALU]))
        else $error("ALU result without an issue one cycle before");

    // Multiplier depth sets the distance back to the issue
    mulFollowsIssue: assert property (@(posedge clk) disable iff (rst)
        resultValid[MUL] |-> $past(issueValid[MUL], `ISSUE_MUL_LAT))
        else $error("multiply result without a matching issue");

endmodule

/* bench/issueTb.sv */
`include "issue_params.svh"

module issueTb
    import issuePkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW = `ISSUE_DATA_W;
    localparam int NU = `ISSUE_NUM_UNITS;
    localparam int REGS = 2 ** `ISSUE_TAG_W;
    localparam int SQN_SPAN = 2 ** `ISSUE_SQN_W;
    localparam int ACCEPT_WAIT = 40;
    localparam int BUDGET_IMM = 40;
    localparam int BUDGET_CHAIN = 40;
    localparam int BUDGET_MUL = 60;
    localparam int BUDGET_FULL = 100;
    localparam int BUDGET_FLUSH = 80;
    localparam int IDLE_WINDOW = 20;
    localparam int CYCLE_LIMIT = 4 + BUDGET_IMM + BUDGET_CHAIN + BUDGET_MUL + BUDGET_FULL
                                 + BUDGET_FLUSH + IDLE_WINDOW + 100;

    logic                         clk;
    logic                         rst;
    logic [`ISSUE_DISPATCH_W-1:0] dispatchValid;
    MicroOp                       dispatchUop [`ISSUE_DISPATCH_W];
    logic                         flushValid;
    SqN                           flushSqN;
    logic                         accept;
    logic [NU-1:0]                resultValid;
    Tag                           resultTag [NU];
    logic [DW-1:0]                resultData [NU];

    // Reference register file and per-tag bookkeeping
    logic [DW-1:0]   modelReg [REGS];
    logic [DW-1:0]   expData [REGS];
    logic [REGS-1:0] expPend;
    logic [REGS-1:0] produced;
    int              bcCycle [REGS];
    Tag              seenTags [$];
    int              pendCount;
    int              cycle = 0;
    int              valueErrs;
    int              otherErrs;
    SqN              nextSqN;
    logic            flushArmed;
    SqN              flushBound;

    issueTop i_dut (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatchUop   (dispatchUop),
        .flushValid    (flushValid),
        .flushSqN      (flushSqN),
        .accept        (accept),
        .resultValid   (resultValid),
        .resultTag     (resultTag),
        .resultData    (resultData)
    );

    bind issueTop issueSva i_sva (
        .clk         (clk),
        .rst         (rst),
        .issueValid  (issueValid),
        .resultValid (resultValid),
        .resultTag   (resultTag)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles before the tests finished", cycle);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic checkData(input string name, input logic [DW-1:0] expected,
                             input logic [DW-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual);
            valueErrs++;
        end
    endtask

    task automatic checkTag(input string name, input Tag expected, input Tag actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual);
            valueErrs++;
        end
    endtask

    task automatic noteResult(input Tag t, input logic [DW-1:0] d);
        if (!expPend[t]) begin
            $display("Result bus broadcast tag 0x%h, which no live op produces", t);
            otherErrs++;
        end else begin
            checkData("resultData", expData[t], d);
            expPend[t] = 1'b0;
            pendCount--;
        end
        produced[t] = 1'b1;
        bcCycle[t] = cycle;
        seenTags.push_back(t);
    endtask

    // Result buses are sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            for (int u = 0; u < NU; u++) begin
                if (resultValid[u]) begin
                    noteResult(resultTag[u], resultData[u]);
                end
            end
        end
    end

    function automatic logic [DW-1:0] readModel(Tag t);
        return (t == '0) ? '0 : modelReg[t];
    endfunction

    function automatic logic [DW-1:0] opValue(MicroOp u);
        logic [DW-1:0] a;
        logic [DW-1:0] b;
        a = readModel(u.tagA);
        b = u.useImm ? DW'(u.imm) : readModel(u.tagB);
        if (u.fu == FU_MUL) begin
            return a * b;
        end
        case (u.op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            default: return a ^ b;
        endcase
    endfunction

    function automatic logic isYounger(SqN a, SqN b);
        int d;
        d = int'(a) - int'(b);
        if (d >= SQN_SPAN / 2) begin
            d = d - SQN_SPAN;
        end else if (d < -(SQN_SPAN / 2)) begin
            d = d + SQN_SPAN;
        end
        return d > 0;
    endfunction

    function automatic MicroOp makeOp(FuType fu, AluOp op, int tagA, int tagB, logic useImm,
                                      int tagDst);
        MicroOp u;
        u = '0;
        u.fu = fu;
        u.op = op;
        u.tagA = Tag'(tagA);
        u.tagB = Tag'(tagB);
        u.useImm = useImm;
        u.imm = useImm ? 16'($urandom) : 16'h0;
        u.tagDst = Tag'(tagDst);
        return u;
    endfunction

    function automatic MicroOp withAvail(MicroOp u);
        MicroOp r;
        r = u;
        r.availA = (u.tagA == '0) || produced[u.tagA];
        r.availB = (u.tagB == '0) || produced[u.tagB];
        return r;
    endfunction

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic sendBundle(input MicroOp a, input MicroOp b, input logic [1:0] valid,
                              output int waited);
        MicroOp slot [2];
        logic   keep;
        slot[0] = a;
        slot[1] = b;
        waited = 0;
        for (int s = 0; s < 2; s++) begin
            if (valid[s]) begin
                slot[s].sqN = nextSqN;
                nextSqN++;
                slot[s] = withAvail(slot[s]);
                produced[slot[s].tagDst] = 1'b0;
            end
        end
        dispatchValid = valid;
        dispatchUop[0] = slot[0];
        dispatchUop[1] = slot[1];
        #1;
        while (!accept) begin
            @(negedge clk);
            waited++;
            if (waited > ACCEPT_WAIT) begin
                $display("accept stayed low for %0d cycles, bundle dropped", waited);
                otherErrs++;
                dispatchValid = '0;
                return;
            end
            // A held bundle picks up sources produced while it waited
            for (int s = 0; s < 2; s++) begin
                slot[s] = valid[s] ? withAvail(slot[s]) : slot[s];
                dispatchUop[s] = slot[s];
            end
            #1;
        end
        for (int s = 0; s < 2; s++) begin
            keep = !(flushArmed && isYounger(slot[s].sqN, flushBound));
            if (valid[s] && keep) begin
                modelReg[slot[s].tagDst] = opValue(slot[s]);
                expData[slot[s].tagDst] = modelReg[slot[s].tagDst];
                expPend[slot[s].tagDst] = 1'b1;
                pendCount++;
            end
        end
        @(negedge clk);
        dispatchValid = '0;
    endtask

    task automatic waitResults(input int budget, input string what);
        int n;
        n = 0;
        while (pendCount > 0 && n < budget) begin
            @(negedge clk);
            n++;
        end
        if (pendCount > 0) begin
            $display("%s: %0d expected results never arrived", what, pendCount);
            otherErrs++;
            expPend = '0;
            pendCount = 0;
        end
    endtask

    task automatic testImmediate();
        int w;
        seenTags.delete();
        sendBundle(makeOp(FU_ALU, ADD, 0, 0, 1'b1, 1), makeOp(FU_ALU, SUB, 0, 0, 1'b1, 2),
                   2'b11, w);
        sendBundle(makeOp(FU_ALU, AND, 0, 0, 1'b1, 3), makeOp(FU_ALU, XOR, 0, 0, 1'b1, 4),
                   2'b11, w);
        waitResults(BUDGET_IMM, "immediate ALU ops");
        if (seenTags.size() != 4) begin
            $display("immediate ALU ops gave %0d broadcasts instead of 4", seenTags.size());
            otherErrs++;
        end
    endtask

    task automatic testChain();
        int w;
        seenTags.delete();
        sendBundle(makeOp(FU_ALU, ADD, 2, 0, 1'b1, 5), makeOp(FU_ALU, SUB, 5, 0, 1'b1, 6),
                   2'b11, w);
        sendBundle(makeOp(FU_ALU, XOR, 6, 4, 1'b0, 7), makeOp(FU_ALU, ADD, 7, 7, 1'b0, 8),
                   2'b11, w);
        waitResults(BUDGET_CHAIN, "dependency chain");
        if (seenTags.size() != 4) begin
            $display("dependency chain gave %0d broadcasts instead of 4", seenTags.size());
            otherErrs++;
        end else begin
            for (int i = 0; i < 4; i++) begin
                checkTag("resultTag", Tag'(5 + i), seenTags[i]);
            end
        end
    endtask

    task automatic testMultiply();
        int w;
        sendBundle(makeOp(FU_MUL, ADD, 1, 0, 1'b1, 9), makeOp(FU_ALU, AND, 5, 0, 1'b1, 10),
                   2'b11, w);
        sendBundle(makeOp(FU_MUL, ADD, 6, 0, 1'b1, 11), makeOp(FU_ALU, SUB, 8, 0, 1'b1, 12),
                   2'b11, w);
        sendBundle(makeOp(FU_MUL, ADD, 7, 8, 1'b0, 13), makeOp(FU_ALU, ADD, 13, 0, 1'b1, 14),
                   2'b11, w);
        waitResults(BUDGET_MUL, "multiply pipeline");
        if (bcCycle[14] <= bcCycle[13]) begin
            $display("ALU op on tag 14 was broadcast before the multiply it depends on");
            otherErrs++;
        end
    endtask

    task automatic testBackPressure();
        int w;
        // Tag 17 comes from the end of a three-multiply chain
        sendBundle(makeOp(FU_MUL, ADD, 9, 0, 1'b1, 15), makeOp(FU_MUL, ADD, 15, 0, 1'b1, 16),
                   2'b11, w);
        sendBundle(makeOp(FU_MUL, ADD, 16, 0, 1'b1, 17), makeOp(FU_ALU, ADD, 17, 0, 1'b1, 18),
                   2'b11, w);
        for (int t = 19; t < 25; t += 2) begin
            sendBundle(makeOp(FU_ALU, XOR, 17, 0, 1'b1, t),
                       makeOp(FU_ALU, SUB, 17, 0, 1'b1, t + 1), 2'b11, w);
        end
        sendBundle(makeOp(FU_ALU, AND, 17, 0, 1'b1, 25), '0, 2'b01, w);
        sendBundle(makeOp(FU_ALU, ADD, 17, 0, 1'b1, 26), '0, 2'b01, w);
        if (w == 0) begin
            $display("accept stayed high with eight ALU ops waiting");
            otherErrs++;
        end
        if (!produced[17]) begin
            $display("accept rose before the awaited source tag was produced");
            otherErrs++;
        end
        waitResults(BUDGET_FULL, "back-pressure");
    endtask

    task automatic testFlush();
        int w;
        flushBound = nextSqN + SqN'(4);
        flushArmed = 1'b1;
        sendBundle(makeOp(FU_MUL, ADD, 9, 0, 1'b1, 27), makeOp(FU_MUL, ADD, 27, 0, 1'b1, 28),
                   2'b11, w);
        sendBundle(makeOp(FU_ALU, ADD, 28, 0, 1'b1, 29), makeOp(FU_MUL, ADD, 28, 10, 1'b0, 30),
                   2'b11, w);
        sendBundle(makeOp(FU_ALU, XOR, 28, 0, 1'b1, 31), makeOp(FU_MUL, ADD, 28, 0, 1'b1, 1),
                   2'b11, w);
        sendBundle(makeOp(FU_ALU, ADD, 28, 0, 1'b1, 2), makeOp(FU_ALU, SUB, 28, 0, 1'b1, 3),
                   2'b11, w);
        flushValid = 1'b1;
        flushSqN = flushBound;
        @(negedge clk);
        flushValid = 1'b0;
        waitResults(BUDGET_FLUSH, "flush");
        // Any late broadcast of a flushed tag shows up in the monitor
        repeat (IDLE_WINDOW) @(negedge clk);
        flushArmed = 1'b0;
    endtask

    initial begin
        void'($urandom(54));
        rst = 1'b1;
        dispatchValid = '0;
        dispatchUop[0] = '0;
        dispatchUop[1] = '0;
        flushValid = 1'b0;
        flushSqN = '0;
        for (int r = 0; r < REGS; r++) begin
            modelReg[r] = '0;
            expData[r] = '0;
            bcCycle[r] = 0;
        end
        expPend = '0;
        produced = '1;
        pendCount = 0;
        valueErrs = 0;
        otherErrs = 0;
        nextSqN = '0;
        flushArmed = 1'b0;
        flushBound = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testImmediate();
        testChain();
        testMultiply();
        testBackPressure();
        testFlush();
        $display("Errors: %0d wrong values, %0d other failures", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/issuePkg.sv
source/dispatchRouter.sv
issueQueue/issueQueue.sv
source/executeWriteback.sv
source/issueTop.sv
bench/issue_sva.sv
bench/issueTb.sv

/* Makefile */
TOP = issueTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f files.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
